// File: flist.f
verilog/wasm_pkg.sv
verilog/leb128_decoder.sv
verilog/opcode_decoder.sv
verilog/section_parser.sv
verilog/wasm_ctrl_top.sv
bench/wasm_ctrl_asserts.sv
bench/tb_wasm_ctrl.sv

// File: bench/wasm_stimulus.txt
// head: stream1 len, stream1+appended len, stream2 len, records, error stop, first record ptr
// record: tag (1 instr, 2 end), alu_op, pop, push, src, flags (load store get set), imm LE
@000
4a 50 08 15 4f 22
@010
00 61 73 6d 01 00 00 00                               // magic and version 1
01 07 01 60 02 7f 7f 01 7f                            // type section
00 0a 04 6e 61 6d 65 01 02 03 04 05                   // custom section
0a 2b 03                                              // code section, three bodies
07 00 20 00 20 01 6a 0b                               // get 0, get 1, add
0c 00 41 e5 8e 26 41 05 6b 22 02 1a 0b                // const, const, sub, tee, drop
14 00 01 20 00 28 02 ac 02 41 01 74 20 01 45 47 1b 36 02 04 0b
0a 04 01 02 00 ff                                     // appended body, unknown opcode
@080
00 61 73 6d 02 00 00 00                               // version 2
@100
01 00 00 01 03 02 00 00 00 00  01 00 00 01 03 02 01 00 00 00
01 00 02 01 00 00 00 00 00 00  02 00 00 00 00 00 00 00 00 00
01 00 00 01 02 00 65 87 09 00  01 00 00 01 02 00 05 00 00 00
01 01 02 01 00 00 00 00 00 00  01 00 00 00 00 01 02 00 00 00
01 00 01 00 00 00 00 00 00 00  02 00 00 00 00 00 00 00 00 00
01 00 00 00 00 00 00 00 00 00  01 00 00 01 03 02 00 00 00 00
01 00 01 01 01 08 2c 01 00 00  01 00 00 01 02 00 01 00 00 00
01 10 02 01 00 00 00 00 00 00  01 00 00 01 03 02 01 00 00 00
01 05 01 01 00 00 00 00 00 00  01 0f 02 01 00 00 00 00 00 00
01 04 03 01 00 00 00 00 00 00  01 00 02 00 00 04 04 00 00 00
02 00 00 00 00 00 00 00 00 00

// File: bench/tb_wasm_ctrl.sv
// testbench top with stream model, stimulus file reader, record checks and report
`timescale 1ns/1ps
`default_nettype none

module tb_wasm_ctrl;

    logic               clk;
    logic               rst_n;
    logic               window_vld;
    wasm_pkg::window_t  window;
    wasm_pkg::advance_t advance;
    wasm_pkg::exec_t    exec;
    logic               func_end;
    logic               header_error;
    logic               format_error;

    logic [7:0]  stim [0:511];
    logic [31:0] seed;
    int ptr, cur_base, cur_len, rec_idx, nrec, fend_cnt, cycles;
    int len1, total1, len2, err_stop, first_ptr;
    int errors, checks, tests, err_mark;

    wasm_ctrl_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .window       (window),
        .window_vld   (window_vld),
        .advance      (advance),
        .exec         (exec),
        .func_end     (func_end),
        .header_error (header_error),
        .format_error (format_error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic timeout_fail(input string what);
        errors++;
        $display("timeout: %s", what);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // eight bytes from the pointer with zeros past the stream end
    task automatic drive_window(input int limit);
        int idx;
        seed = lcg_next(seed);
        for (int i = 0; i < wasm_pkg::WINDOW_BYTES; i++) begin
            idx = ptr + i;
            window[i*8 +: 8] = (idx < cur_len) ? stim[cur_base + idx] : 8'h00;
        end
        window_vld = (ptr < limit) && (seed[17:16] != 2'b00);   // stall about 1 in 4
    endtask

    task automatic score_record(input logic [7:0] tag);
        int b;
        b = 'h100 + rec_idx * 10;
        if (rec_idx >= nrec) begin
            errors++;
            $display("unexpected record at stream pointer %0d", ptr);
        end else begin
            if (rec_idx == 0) check_eq("first record pointer", first_ptr, ptr);
            check_eq($sformatf("record %0d tag", rec_idx), stim[b], tag);
            if (tag == 8'd1) begin
                check_eq($sformatf("record %0d alu_op", rec_idx), stim[b+1], exec.alu_op);
                check_eq($sformatf("record %0d pop_num", rec_idx), stim[b+2], exec.pop_num);
                check_eq($sformatf("record %0d push_num", rec_idx), stim[b+3], exec.push_num);
                check_eq($sformatf("record %0d push_src", rec_idx), stim[b+4], exec.push_src);
                check_eq($sformatf("record %0d flags", rec_idx), stim[b+5][3:0],
                         {exec.load_en, exec.store_en, exec.local_get, exec.local_set});
                check_eq($sformatf("record %0d immediate", rec_idx),
                         {stim[b+9], stim[b+8], stim[b+7], stim[b+6]}, exec.immediate);
            end
            rec_idx++;
        end
    endtask

    // sample mid-cycle then move the pointer and drive after the edge
    task automatic step_cycle(input int limit);
        int adv;
        adv = 0;
        @(negedge clk);
        if (window_vld) begin
            adv = advance;
            if (exec.valid) score_record(8'd1);
            if (func_end) begin
                fend_cnt++;
                score_record(8'd2);
            end
        end else begin
            check_eq("exec.valid while stalled", 0, exec.valid);
            check_eq("func_end while stalled", 0, func_end);
        end
        @(posedge clk);
        #1;
        ptr = ptr + adv;
        drive_window(limit);
    endtask

    task automatic apply_reset();
        rst_n      = 1'b0;
        window_vld = 1'b0;
        ptr        = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    initial begin
        rst_n      = 1'b0;
        window_vld = 1'b0;
        window     = '0;
        seed       = 32'd30899;
        ptr        = 0;
        rec_idx    = 0;
        fend_cnt   = 0;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        err_mark   = 0;
        $readmemh("bench/wasm_stimulus.txt", stim);
        len1      = stim[0];
        total1    = stim[1];
        len2      = stim[2];
        nrec      = stim[3];
        err_stop  = stim[4];
        first_ptr = stim[5];
        cur_base  = 'h10;
        cur_len   = total1;
        apply_reset();
        drive_window(len1);

        cycles = 0;
        while (ptr < 8 && !header_error && cycles < 20) begin
            step_cycle(len1);
            cycles++;
        end
        if (ptr < 8 && !header_error) timeout_fail("header not consumed in 20 cycles");
        check_eq("header_error after header", 0, header_error);
        check_eq("pointer after header", 8, ptr);
        end_test("header_accept");

        cycles = 0;
        while (rec_idx < 1 && cycles < 100) begin
            step_cycle(len1);
            cycles++;
        end
        if (rec_idx < 1) timeout_fail("no record after the skipped sections");
        end_test("section_skip");

        cycles = 0;
        while ((rec_idx < nrec || ptr < len1) && cycles < 300) begin
            step_cycle(len1);
            cycles++;
        end
        if (rec_idx < nrec || ptr < len1) timeout_fail("code section records incomplete");
        check_eq("record count", nrec, rec_idx);
        end_test("instr_records");

        repeat (3) step_cycle(len1);   // pointer must hold at the stream end
        check_eq("final pointer", len1, ptr);
        check_eq("func_end count", 3, fend_cnt);
        end_test("code_end");

        cycles = 0;
        while (!format_error && cycles < 50) begin
            step_cycle(total1);
            cycles++;
        end
        if (!format_error) timeout_fail("format_error not raised by unknown opcode");
        repeat (4) step_cycle(total1);
        check_eq("format_error", 1, format_error);
        check_eq("pointer at unknown opcode", err_stop, ptr);
        end_test("unknown_opcode");

        cur_base = 'h80;
        cur_len  = len2;
        apply_reset();
        drive_window(len2);
        cycles = 0;
        while (!header_error && cycles < 20) begin
            step_cycle(len2);
            cycles++;
        end
        if (!header_error) timeout_fail("header_error not raised by bad header");
        repeat (3) step_cycle(len2);
        check_eq("header_error bad header", 1, header_error);
        check_eq("pointer after bad header", 0, ptr);
        end_test("bad_header");

        if (DUT.u_asserts.fail_cnt != 0) begin
            $display("%0d assertion failures in the bound checker", DUT.u_asserts.fail_cnt);
            errors = errors + DUT.u_asserts.fail_cnt;
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/wasm_ctrl_asserts.sv
// concurrent assertions on the wasm_ctrl_top outputs and their bind into the DUT
`timescale 1ns/1ps
`default_nettype none

module wasm_ctrl_asserts (
    input logic               clk,
    input logic               rst_n,
    input logic               window_vld,
    input wasm_pkg::advance_t advance,
    input wasm_pkg::exec_t    exec,
    input logic               func_end,
    input logic               header_error,
    input logic               format_error
);

    int fail_cnt = 0;   // failed assertion attempts

    a_no_adv_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        !window_vld |-> advance == '0)
        else begin
            fail_cnt++;
            $error("advance nonzero while window_vld is low");
        end

    a_exec_xor_end: assert property (@(posedge clk) disable iff (!rst_n)
        !(exec.valid && func_end))
        else begin
            fail_cnt++;
            $error("exec.valid and func_end high together");
        end

    a_adv_range: assert property (@(posedge clk) disable iff (!rst_n)
        advance <= 4'd8)
        else begin
            fail_cnt++;
            $error("advance above eight bytes");
        end

    a_hdr_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        header_error |=> header_error)
        else begin
            fail_cnt++;
            $error("header_error dropped");
        end

    a_fmt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        format_error |=> format_error)
        else begin
            fail_cnt++;
            $error("format_error dropped");
        end

endmodule

bind wasm_ctrl_top wasm_ctrl_asserts u_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .window_vld   (window_vld),
    .advance      (advance),
    .exec         (exec),
    .func_end     (func_end),
    .header_error (header_error),
    .format_error (format_error)
);

`default_nettype wire

// File: verilog/wasm_ctrl_top.sv
// top level joining the LEB128 decoder, opcode decoder and section parser
`timescale 1ns/1ps
`default_nettype none

module wasm_ctrl_top (
    input  logic               clk,
    input  logic               rst_n,
    input  wasm_pkg::window_t  window,
    input  logic               window_vld,
    output wasm_pkg::advance_t advance,
    output wasm_pkg::exec_t    exec,
    output logic               func_end,
    output logic               header_error,
    output logic               format_error
);

    wasm_pkg::leb_bytes_t leb_bytes;
    wasm_pkg::word_t      leb_value;
    wasm_pkg::leb_cnt_t   leb_cnt;
    wasm_pkg::op_ctrl_t   op_ctrl;

    leb128_decoder u_leb (
        .leb_bytes (leb_bytes),
        .leb_value (leb_value),
        .leb_cnt   (leb_cnt)
    );

    opcode_decoder u_opdec (
        .opcode  (window[7:0]),   // opcode is always the first window byte
        .op_ctrl (op_ctrl)
    );

    section_parser u_parser (
        .clk          (clk),
        .rst_n        (rst_n),
        .window       (window),
        .window_vld   (window_vld),
        .leb_value    (leb_value),
        .leb_cnt      (leb_cnt),
        .op_ctrl      (op_ctrl),
        .leb_bytes    (leb_bytes),
        .advance      (advance),
        .exec         (exec),
        .func_end     (func_end),
        .header_error (header_error),
        .format_error (format_error)
    );

endmodule

`default_nettype wire

// File: verilog/section_parser.sv
// module parser FSM with LEB offset select, advance count, skip and function counters
`timescale 1ns/1ps
`default_nettype none

module section_parser (
    input  logic                 clk,
    input  logic                 rst_n,
    input  wasm_pkg::window_t    window,
    input  logic                 window_vld,
    input  wasm_pkg::word_t      leb_value,
    input  wasm_pkg::leb_cnt_t   leb_cnt,
    input  wasm_pkg::op_ctrl_t   op_ctrl,
    output wasm_pkg::leb_bytes_t leb_bytes,
    output wasm_pkg::advance_t   advance,
    output wasm_pkg::exec_t      exec,
    output logic                 func_end,
    output logic                 header_error,
    output logic                 format_error
);

    wasm_pkg::parse_state_e state, state_nxt;
    wasm_pkg::word_t        skip_cnt, skip_nxt;     // bytes left in a skipped section
    wasm_pkg::word_t        func_left, func_nxt;    // bodies left in the code section
    wasm_pkg::advance_t     adv_raw;
    wasm_pkg::advance_t     leb_adv;
    wasm_pkg::byte_t        sec_id;
    logic                   hdr_err_set;
    logic                   fmt_err_set;
    logic                   instr_ok;
    logic [1:0]             leb_off;

    assign sec_id  = window[7:0];
    assign leb_adv = wasm_pkg::advance_t'(leb_cnt);
    assign instr_ok = (state == wasm_pkg::st_body_instr) && op_ctrl.known;

    // LEB field sits after the opcode/id byte, or after the memarg align byte
    always_comb begin
        leb_off = 2'd0;
        if (state == wasm_pkg::st_section_head) begin
            leb_off = 2'd1;
        end else if (state == wasm_pkg::st_body_instr) begin
            leb_off = (op_ctrl.imm_kind == wasm_pkg::imm_memarg) ? 2'd2 : 2'd1;
        end
    end

    always_comb begin
        case (leb_off)
            2'd1:    leb_bytes = window[8 +: 40];
            2'd2:    leb_bytes = window[16 +: 40];
            default: leb_bytes = window[0 +: 40];
        endcase
    end

    always_comb begin
        state_nxt   = state;
        skip_nxt    = skip_cnt;
        func_nxt    = func_left;
        adv_raw     = '0;
        hdr_err_set = 1'b0;
        fmt_err_set = 1'b0;
        unique case (state)
            wasm_pkg::st_module_head: begin
                if (window == wasm_pkg::WASM_MAGIC_VERSION) begin
                    adv_raw   = 4'd8;
                    state_nxt = wasm_pkg::st_section_head;
                end else begin
                    hdr_err_set = 1'b1;
                    state_nxt   = wasm_pkg::st_halt;
                end
            end
            wasm_pkg::st_section_head: begin
                adv_raw = leb_adv + 4'd1;
                if (sec_id == wasm_pkg::SEC_CODE) begin
                    state_nxt = wasm_pkg::st_func_count;
                end else if (leb_value != '0) begin
                    skip_nxt  = leb_value;
                    state_nxt = wasm_pkg::st_skip;
                end
            end
            wasm_pkg::st_skip: begin
                if (skip_cnt < wasm_pkg::word_t'(wasm_pkg::WINDOW_BYTES)) begin
                    adv_raw = wasm_pkg::advance_t'(skip_cnt);
                end else begin
                    adv_raw = wasm_pkg::advance_t'(wasm_pkg::WINDOW_BYTES);
                end
                skip_nxt = skip_cnt - wasm_pkg::word_t'(adv_raw);
                if (skip_nxt == '0) state_nxt = wasm_pkg::st_section_head;
            end
            wasm_pkg::st_func_count: begin
                adv_raw   = leb_adv;
                func_nxt  = leb_value;
                state_nxt = (leb_value == '0) ? wasm_pkg::st_section_head
                                              : wasm_pkg::st_body_size;
            end
            wasm_pkg::st_body_size: begin
                adv_raw   = leb_adv;   // size itself is not needed
                state_nxt = wasm_pkg::st_body_locals;
            end
            wasm_pkg::st_body_locals: begin
                adv_raw = leb_adv;
                if (leb_value != '0) begin
                    fmt_err_set = 1'b1;   // local declarations not supported
                    state_nxt   = wasm_pkg::st_halt;
                end else begin
                    state_nxt = wasm_pkg::st_body_instr;
                end
            end
            wasm_pkg::st_body_instr: begin
                if (!op_ctrl.known) begin
                    fmt_err_set = 1'b1;
                    state_nxt   = wasm_pkg::st_halt;
                end else begin
                    case (op_ctrl.imm_kind)
                        wasm_pkg::imm_leb:    adv_raw = leb_adv + 4'd1;
                        wasm_pkg::imm_memarg: adv_raw = leb_adv + 4'd2;
                        default:              adv_raw = 4'd1;
                    endcase
                    if (op_ctrl.is_end) begin
                        func_nxt  = func_left - 32'd1;
                        state_nxt = (func_left == 32'd1) ? wasm_pkg::st_section_head
                                                         : wasm_pkg::st_body_size;
                    end
                end
            end
            default: adv_raw = '0;   // halt
        endcase
    end

    assign advance  = window_vld ? adv_raw : '0;
    assign func_end = window_vld && instr_ok && op_ctrl.is_end;

    always_comb begin
        exec.valid     = window_vld && instr_ok && !op_ctrl.is_end;
        exec.alu_op    = op_ctrl.alu_op;
        exec.pop_num   = op_ctrl.pop_num;
        exec.push_num  = op_ctrl.push_num;
        exec.push_src  = op_ctrl.push_src;
        exec.load_en   = op_ctrl.load_en;
        exec.store_en  = op_ctrl.store_en;
        exec.local_get = op_ctrl.local_get;
        exec.local_set = op_ctrl.local_set;
        exec.immediate = (op_ctrl.imm_kind == wasm_pkg::imm_none) ? '0 : leb_value;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= wasm_pkg::st_module_head;
            skip_cnt     <= '0;
            func_left    <= '0;
            header_error <= 1'b0;
            format_error <= 1'b0;
        end else if (window_vld) begin
            state     <= state_nxt;
            skip_cnt  <= skip_nxt;
            func_left <= func_nxt;
            if (hdr_err_set) header_error <= 1'b1;   // sticky
            if (fmt_err_set) format_error <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/opcode_decoder.sv
// opcode to stack, ALU, memory and local control record table
`timescale 1ns/1ps
`default_nettype none

module opcode_decoder (
    input  wasm_pkg::byte_t    opcode,
    output wasm_pkg::op_ctrl_t op_ctrl
);

    // stack op that pushes one ALU result
    function automatic wasm_pkg::op_ctrl_t alu_ctrl(
        input wasm_pkg::alu_op_e op,
        input logic [1:0]        pops
    );
        wasm_pkg::op_ctrl_t c;
        c          = '0;
        c.known    = 1'b1;
        c.imm_kind = wasm_pkg::imm_none;
        c.alu_op   = op;
        c.pop_num  = pops;
        c.push_num = 1'b1;
        c.push_src = wasm_pkg::src_alu;
        return c;
    endfunction

    always_comb begin
        op_ctrl          = '0;
        op_ctrl.known    = 1'b1;
        op_ctrl.imm_kind = wasm_pkg::imm_none;
        op_ctrl.alu_op   = wasm_pkg::alu_add;
        op_ctrl.push_src = wasm_pkg::src_alu;
        case (opcode)
            wasm_pkg::OP_NOP:    op_ctrl.pop_num = 2'd0;   // no stack effect
            wasm_pkg::OP_END:    op_ctrl.is_end = 1'b1;
            wasm_pkg::OP_DROP:   op_ctrl.pop_num = 2'd1;
            wasm_pkg::OP_SELECT: op_ctrl = alu_ctrl(wasm_pkg::alu_select, 2'd3);
            wasm_pkg::OP_EQZ:    op_ctrl = alu_ctrl(wasm_pkg::alu_eqz, 2'd1);
            wasm_pkg::OP_EQ:     op_ctrl = alu_ctrl(wasm_pkg::alu_eq, 2'd2);
            wasm_pkg::OP_NE:     op_ctrl = alu_ctrl(wasm_pkg::alu_ne, 2'd2);
            wasm_pkg::OP_LT_S:   op_ctrl = alu_ctrl(wasm_pkg::alu_lt_s, 2'd2);
            wasm_pkg::OP_LT_U:   op_ctrl = alu_ctrl(wasm_pkg::alu_lt_u, 2'd2);
            wasm_pkg::OP_GT_S:   op_ctrl = alu_ctrl(wasm_pkg::alu_gt_s, 2'd2);
            wasm_pkg::OP_GT_U:   op_ctrl = alu_ctrl(wasm_pkg::alu_gt_u, 2'd2);
            wasm_pkg::OP_LE_S:   op_ctrl = alu_ctrl(wasm_pkg::alu_le_s, 2'd2);
            wasm_pkg::OP_LE_U:   op_ctrl = alu_ctrl(wasm_pkg::alu_le_u, 2'd2);
            wasm_pkg::OP_GE_S:   op_ctrl = alu_ctrl(wasm_pkg::alu_ge_s, 2'd2);
            wasm_pkg::OP_GE_U:   op_ctrl = alu_ctrl(wasm_pkg::alu_ge_u, 2'd2);
            wasm_pkg::OP_ADD:    op_ctrl = alu_ctrl(wasm_pkg::alu_add, 2'd2);
            wasm_pkg::OP_SUB:    op_ctrl = alu_ctrl(wasm_pkg::alu_sub, 2'd2);
            wasm_pkg::OP_AND:    op_ctrl = alu_ctrl(wasm_pkg::alu_and, 2'd2);
            wasm_pkg::OP_OR:     op_ctrl = alu_ctrl(wasm_pkg::alu_or, 2'd2);
            wasm_pkg::OP_SHL:    op_ctrl = alu_ctrl(wasm_pkg::alu_shl, 2'd2);
            wasm_pkg::OP_SHR_S:  op_ctrl = alu_ctrl(wasm_pkg::alu_shr_s, 2'd2);
            wasm_pkg::OP_SHR_U:  op_ctrl = alu_ctrl(wasm_pkg::alu_shr_u, 2'd2);
            wasm_pkg::OP_ROTL:   op_ctrl = alu_ctrl(wasm_pkg::alu_rotl, 2'd2);
            wasm_pkg::OP_ROTR:   op_ctrl = alu_ctrl(wasm_pkg::alu_rotr, 2'd2);
            wasm_pkg::OP_CONST: begin
                op_ctrl.imm_kind = wasm_pkg::imm_leb;
                op_ctrl.push_num = 1'b1;
                op_ctrl.push_src = wasm_pkg::src_imm;
            end
            wasm_pkg::OP_LOCAL_GET: begin
                op_ctrl.imm_kind  = wasm_pkg::imm_leb;   // local index
                op_ctrl.push_num  = 1'b1;
                op_ctrl.push_src  = wasm_pkg::src_local;
                op_ctrl.local_get = 1'b1;
            end
            wasm_pkg::OP_LOCAL_SET: begin
                op_ctrl.imm_kind  = wasm_pkg::imm_leb;
                op_ctrl.pop_num   = 2'd1;
                op_ctrl.local_set = 1'b1;
            end
            wasm_pkg::OP_LOCAL_TEE: begin
                op_ctrl.imm_kind  = wasm_pkg::imm_leb;
                op_ctrl.local_set = 1'b1;                // value stays on the stack
            end
            wasm_pkg::OP_LOAD: begin
                op_ctrl.imm_kind = wasm_pkg::imm_memarg;
                op_ctrl.pop_num  = 2'd1;                 // address
                op_ctrl.push_num = 1'b1;
                op_ctrl.push_src = wasm_pkg::src_mem;
                op_ctrl.load_en  = 1'b1;
            end
            wasm_pkg::OP_STORE: begin
                op_ctrl.imm_kind = wasm_pkg::imm_memarg;
                op_ctrl.pop_num  = 2'd2;                 // address and value
                op_ctrl.store_en = 1'b1;
            end
            default: op_ctrl.known = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/leb128_decoder.sv
// combinational unsigned LEB128 decoder, up to five bytes
`timescale 1ns/1ps
`default_nettype none

module leb128_decoder (
    input  wasm_pkg::leb_bytes_t leb_bytes,
    output wasm_pkg::word_t      leb_value,
    output wasm_pkg::leb_cnt_t   leb_cnt
);

    logic [wasm_pkg::LEB_MAX_BYTES*7-1:0] groups;   // all seven-bit groups, low first
    logic                                 stop;

    always_comb begin
        groups  = '0;
        stop    = 1'b0;
        leb_cnt = wasm_pkg::leb_cnt_t'(wasm_pkg::LEB_MAX_BYTES);   // no terminator seen
        for (int i = 0; i < wasm_pkg::LEB_MAX_BYTES; i++) begin
            if (!stop) begin
                groups[i*7 +: 7] = leb_bytes[i*8 +: 7];
                if (!leb_bytes[i*8+7]) begin   // continuation bit clear
                    stop    = 1'b1;
                    leb_cnt = wasm_pkg::leb_cnt_t'(i + 1);
                end
            end
        end
        // upper bits of the fifth group fall outside u32
        leb_value = groups[31:0];
    end

endmodule

`default_nettype wire

// File: verilog/wasm_pkg.sv
// stream widths, opcode and section codes, control enums and record structs
`default_nettype none

package wasm_pkg;

    typedef logic [63:0] window_t;     // byte 0 in bits 7:0
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  advance_t;    // 0..8 bytes per cycle
    typedef logic [2:0]  leb_cnt_t;    // 1..5
    typedef logic [39:0] leb_bytes_t;

    localparam int WINDOW_BYTES  = 8;
    localparam int LEB_MAX_BYTES = 5;

    // "\0asm" followed by version 1, little endian
    localparam window_t WASM_MAGIC_VERSION = 64'h0000_0001_6d73_6100;

    localparam byte_t SEC_CODE = 8'd10;

    localparam byte_t OP_NOP       = 8'h01;
    localparam byte_t OP_END       = 8'h0b;
    localparam byte_t OP_DROP      = 8'h1a;
    localparam byte_t OP_SELECT    = 8'h1b;
    localparam byte_t OP_LOCAL_GET = 8'h20;
    localparam byte_t OP_LOCAL_SET = 8'h21;
    localparam byte_t OP_LOCAL_TEE = 8'h22;
    localparam byte_t OP_LOAD      = 8'h28;
    localparam byte_t OP_STORE     = 8'h36;
    localparam byte_t OP_CONST     = 8'h41;
    localparam byte_t OP_EQZ       = 8'h45;
    localparam byte_t OP_EQ        = 8'h46;
    localparam byte_t OP_NE        = 8'h47;
    localparam byte_t OP_LT_S      = 8'h48;
    localparam byte_t OP_LT_U      = 8'h49;
    localparam byte_t OP_GT_S      = 8'h4a;
    localparam byte_t OP_GT_U      = 8'h4b;
    localparam byte_t OP_LE_S      = 8'h4c;
    localparam byte_t OP_LE_U      = 8'h4d;
    localparam byte_t OP_GE_S      = 8'h4e;
    localparam byte_t OP_GE_U      = 8'h4f;
    localparam byte_t OP_ADD       = 8'h6a;
    localparam byte_t OP_SUB       = 8'h6b;
    localparam byte_t OP_AND       = 8'h71;
    localparam byte_t OP_OR        = 8'h72;
    localparam byte_t OP_SHL       = 8'h74;
    localparam byte_t OP_SHR_S     = 8'h75;
    localparam byte_t OP_SHR_U     = 8'h76;
    localparam byte_t OP_ROTL      = 8'h77;
    localparam byte_t OP_ROTR      = 8'h78;

    typedef enum logic [4:0] {
        alu_add    = 5'd0,
        alu_sub    = 5'd1,
        alu_and    = 5'd2,
        alu_or     = 5'd3,
        alu_select = 5'd4,
        alu_eqz    = 5'd5,
        alu_eq     = 5'd6,
        alu_lt_u   = 5'd7,
        alu_gt_u   = 5'd8,
        alu_le_u   = 5'd9,
        alu_ge_u   = 5'd10,
        alu_lt_s   = 5'd11,
        alu_gt_s   = 5'd12,
        alu_le_s   = 5'd13,
        alu_ge_s   = 5'd14,
        alu_ne     = 5'd15,
        alu_shl    = 5'd16,
        alu_shr_s  = 5'd17,
        alu_shr_u  = 5'd18,
        alu_rotl   = 5'd19,
        alu_rotr   = 5'd20
    } alu_op_e;

    typedef enum logic [1:0] {src_alu, src_mem, src_imm, src_local} push_src_e;

    typedef enum logic [1:0] {imm_none, imm_leb, imm_memarg} imm_kind_e;

    typedef enum logic [2:0] {
        st_module_head, st_section_head, st_skip, st_func_count,
        st_body_size, st_body_locals, st_body_instr, st_halt
    } parse_state_e;

    typedef struct packed {
        logic      known;
        logic      is_end;
        imm_kind_e imm_kind;
        alu_op_e   alu_op;
        logic [1:0] pop_num;
        logic      push_num;
        push_src_e push_src;
        logic      load_en;
        logic      store_en;
        logic      local_get;
        logic      local_set;
    } op_ctrl_t;

    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        logic [1:0] pop_num;
        logic      push_num;
        push_src_e push_src;
        logic      load_en;
        logic      store_en;
        logic      local_get;
        logic      local_set;
        word_t     immediate;
    } exec_t;

endpackage

`default_nettype wire
